// ==== flist.f ====
logic/soc_pkg.sv
logic/axil_req_stage.sv
logic/addr_decode_stage.sv
logic/clint_regs.sv
logic/target_stage.sv
logic/axil_rsp_stage.sv
logic/soc_sim_top.sv
test/soc_sim_assertions.sv
test/tb_clock.sv
test/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o tb_sim
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

// ==== test/tb_top.sv ====
// Simulation top that drives AXI4-Lite traffic into the subsystem and checks it against a reference model
`default_nettype none

module tb_top import soc_pkg::*; ();

  typedef struct packed {
    logic                 write;
    logic                 chk;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      rtc;
  logic      timer_irq;
  logic      ipi;
  axil_req_t req;
  axil_rsp_t rsp;

  logic [DataWidth-1:0] sram_ref [SramWords];
  logic [7:0]           used_idx [8];
  exp_t                 exp_q [$];
  logic [DataWidth-1:0] last_rdata;
  longint               mtime_diff;
  int                   max_wait = 200;
  int                   errors;
  int                   timeouts;
  int                   rtc_div;
  int                   rtc_edges;

  tb_clock i_clock (
    .clk_o ( clk )
  );

  soc_sim_top dut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .axil_req_i  ( req       ),
    .axil_rsp_o  ( rsp       ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       )
  );

  // Slow real time clock toggling every 10 cycles
  always @(posedge clk) begin
    if (rst_n) begin
      if (rtc_div == 9) begin
        rtc_div <= 0;
        rtc     <= !rtc;
        if (!rtc) rtc_edges <= rtc_edges + 1;
      end else begin
        rtc_div <= rtc_div + 1;
      end
    end
  end

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
      input logic [DataWidth-1:0] new_word, input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] res;
    res = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [AddrWidth-1:0] sram_addr(input logic [7:0] idx);
    return SramBase + AddrWidth'(idx) * 8;
  endfunction

  // Reference model applied in issue order
  function automatic exp_t expect_rsp(input logic wr, input logic [AddrWidth-1:0] addr,
      input logic [DataWidth-1:0] data, input logic [StrbWidth-1:0] strb);
    exp_t e;
    int   idx;
    e.write = wr;
    e.chk   = !wr;
    e.data  = '0;
    e.resp  = RespOkay;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      if (wr) e.resp = RespSlvErr;
      else e.data = RomContent[int'((addr - RomBase) >> 3)];
    end else if (addr >= SramBase && addr < SramBase + SramLength) begin
      idx = int'((addr - SramBase) >> 3);
      if (wr) sram_ref[idx] = merge_bytes(sram_ref[idx], data, strb);
      else e.data = sram_ref[idx];
    end else if (addr >= ClintBase && addr < ClintBase + ClintLength) begin
      e.chk = 1'b0;
    end else if (addr >= GpioBase && addr < GpioBase + GpioLength) begin
      e.resp = RespSlvErr;
    end else begin
      e.resp = RespDecErr;
    end
    return e;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic issue_req(input logic wr, input logic [AddrWidth-1:0] addr,
      input logic [DataWidth-1:0] data, input logic [StrbWidth-1:0] strb);
    int   n;
    logic done;
    exp_q.push_back(expect_rsp(wr, addr, data, strb));
    if (wr) begin
      req.aw_valid <= 1'b1;
      req.aw_addr  <= addr;
      req.w_valid  <= 1'b1;
      req.w_data   <= data;
      req.w_strb   <= strb;
    end else begin
      req.ar_valid <= 1'b1;
      req.ar_addr  <= addr;
    end
    n = 0;
    done = 1'b0;
    while (!done && n < max_wait) begin
      @(posedge clk);
      done = wr ? (rsp.aw_ready && rsp.w_ready) : rsp.ar_ready;
      n++;
    end
    if (!done) begin
      $display("Timeout: request to address %h was never accepted", addr);
      timeouts++;
    end
    req.aw_valid <= 1'b0;
    req.w_valid  <= 1'b0;
    req.ar_valid <= 1'b0;
  endtask

  task automatic collect_rsp(input string name, input bit rand_ready);
    int   n;
    logic done;
    logic got_wr;
    exp_t e;
    n = 0;
    done = 1'b0;
    while (!done && n < max_wait) begin
      @(posedge clk);
      got_wr = rsp.b_valid && req.b_ready;
      done   = got_wr || (rsp.r_valid && req.r_ready);
      if (done) begin
        e = exp_q.pop_front();
        last_rdata = rsp.r_data;
        check_equal({name, " channel"}, 64'(e.write), 64'(got_wr));
        check_equal({name, " resp"}, 64'(e.resp), 64'(got_wr ? rsp.b_resp : rsp.r_resp));
        if (e.chk) check_equal({name, " data"}, e.data, rsp.r_data);
      end
      if (rand_ready) begin
        req.b_ready <= 1'($urandom_range(0, 1));
        req.r_ready <= 1'($urandom_range(0, 1));
      end
      n++;
    end
    if (!done) begin
      $display("Timeout: no response arrived for %s", name);
      timeouts++;
    end
  endtask

  task automatic access(input string name, input logic wr, input logic [AddrWidth-1:0] addr,
      input logic [DataWidth-1:0] data, input logic [StrbWidth-1:0] strb);
    issue_req(wr, addr, data, strb);
    collect_rsp(name, 1'b0);
  endtask

  initial begin
    void'($urandom(52));
    req       = '0;
    rst_n     = 1'b0;
    rtc       = 1'b0;
    errors    = 0;
    timeouts  = 0;
    rtc_div   = 0;
    rtc_edges = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_equal("reset handshake", 64'd0, 64'({rsp.aw_ready, rsp.w_ready, rsp.ar_ready,
                                                rsp.b_valid, rsp.r_valid}));
    check_equal("reset irq", 64'd0, 64'({timer_irq, ipi}));
    req.b_ready <= 1'b1;
    req.r_ready <= 1'b1;

    // Full SRAM writes first so every read word is defined
    for (int i = 0; i < 8; i++) begin
      used_idx[i] = 8'($urandom_range(0, SramWords - 1));
      access("sram init", 1'b1, sram_addr(used_idx[i]), {$urandom, $urandom}, 8'hff);
    end
    for (int i = 0; i < 16; i++) begin
      access("sram write", 1'b1, sram_addr(used_idx[$urandom_range(0, 7)]),
             {$urandom, $urandom}, 8'($urandom));
    end
    for (int i = 0; i < 8; i++) access("sram read", 1'b0, sram_addr(used_idx[i]), '0, '0);

    for (int i = 0; i < RomWords; i++) access("rom read", 1'b0, RomBase + 32'(i * 8), '0, '0);
    access("rom write", 1'b1, RomBase + 32'h18, {$urandom, $urandom}, 8'hff);
    access("rom reread", 1'b0, RomBase + 32'h18, '0, '0);

    access("gpio read", 1'b0, GpioBase + 32'h10, '0, '0);
    access("gpio write", 1'b1, GpioBase + 32'h10, {$urandom, $urandom}, 8'hff);
    access("unmapped read", 1'b0, 32'h1000_0000, '0, '0);
    access("unmapped write", 1'b1, 32'h1000_0000, {$urandom, $urandom}, 8'hff);

    // CLINT
    access("msip set", 1'b1, ClintBase + AddrWidth'(MsipOffset), 64'd1, 8'h01);
    check_equal("ipi set", 64'd1, 64'(ipi));
    access("msip clear", 1'b1, ClintBase + AddrWidth'(MsipOffset), 64'd0, 8'h01);
    check_equal("ipi clear", 64'd0, 64'(ipi));
    repeat (60) @(posedge clk);
    access("mtime read", 1'b0, ClintBase + AddrWidth'(MtimeOffset), '0, '0);
    mtime_diff = longint'(last_rdata) - longint'(rtc_edges);
    assert (mtime_diff >= -1 && mtime_diff <= 1) else begin
      $display("ERR mtime read expected %0d actual %0d", rtc_edges, last_rdata);
      errors++;
    end
    access("mtimecmp low", 1'b1, ClintBase + AddrWidth'(MtimecmpOffset), 64'd0, 8'hff);
    check_equal("timer irq raise", 64'd1, 64'(timer_irq));
    access("mtimecmp high", 1'b1, ClintBase + AddrWidth'(MtimecmpOffset), '1, 8'hff);
    check_equal("timer irq clear", 64'd0, 64'(timer_irq));

    // Six mixed requests behind stalled B and R channels
    req.b_ready <= 1'b0;
    req.r_ready <= 1'b0;
    fork
      begin
        issue_req(1'b1, sram_addr(used_idx[0]), {$urandom, $urandom}, 8'($urandom));
        issue_req(1'b0, sram_addr(used_idx[0]), '0, '0);
        issue_req(1'b0, RomBase + 32'h28, '0, '0);
        issue_req(1'b1, GpioBase, {$urandom, $urandom}, 8'hff);
        issue_req(1'b0, 32'h1000_0000, '0, '0);
        issue_req(1'b1, sram_addr(used_idx[1]), {$urandom, $urandom}, 8'hff);
      end
      begin
        repeat (10) @(posedge clk);
        repeat (6) collect_rsp("backpressure", 1'b1);
      end
    join

    // A read response waiting at the head of a stalled R channel
    req.b_ready <= 1'b1;
    req.r_ready <= 1'b0;
    issue_req(1'b0, sram_addr(used_idx[1]), '0, '0);
    repeat (6) @(posedge clk);
    req.r_ready <= 1'b1;
    collect_rsp("backpressure read", 1'b0);

    repeat (5) @(posedge clk);
    $display("Errors: %0d data, %0d timeouts, %0d assertions",
             errors, timeouts, dut.u_assertions.fail_count);
    if (errors == 0 && timeouts == 0 && dut.u_assertions.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Free running testbench clock with a period of 100 time units, instantiated by the testbench top
`default_nettype none

module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = !clk_o;
  end

endmodule

`default_nettype wire

// ==== test/soc_sim_assertions.sv ====
// Protocol, latency and interrupt assertions, bound onto the subsystem top by the bind below
`default_nettype none

module soc_sim_assertions import soc_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input axil_req_t axil_req_i,
  input axil_rsp_t axil_rsp_i,
  input logic      req_valid_i,
  input logic      dec_valid_i,
  input logic      rsp_valid_i,
  input logic      ipi_i
);

  int   fail_count = 0;
  logic msip_shadow_q;
  logic idle;
  logic rsp_stuck;

  assign idle = !req_valid_i && !dec_valid_i && !rsp_valid_i &&
                !axil_rsp_i.b_valid && !axil_rsp_i.r_valid;
  assign rsp_stuck = (axil_rsp_i.b_valid && !axil_req_i.b_ready) ||
                     (axil_rsp_i.r_valid && !axil_req_i.r_ready);

  // Last msip bit accepted on the write channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_shadow_q <= 1'b0;
    end else if (axil_req_i.aw_valid && axil_rsp_i.aw_ready && axil_req_i.w_strb[0] &&
                 axil_req_i.aw_addr == ClintBase + AddrWidth'(MsipOffset)) begin
      msip_shadow_q <= axil_req_i.w_data[0];
    end
  end

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.b_valid && !axil_req_i.b_ready |=>
      axil_rsp_i.b_valid && $stable(axil_rsp_i.b_resp))
    else begin
      $error("B response dropped or changed before bready");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.r_valid && !axil_req_i.r_ready |=>
      axil_rsp_i.r_valid && $stable(axil_rsp_i.r_data) && $stable(axil_rsp_i.r_resp))
    else begin
      $error("R response dropped or changed before rready");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk_i) $rose(rst_ni) |->
    !(axil_rsp_i.aw_ready || axil_rsp_i.w_ready || axil_rsp_i.ar_ready ||
      axil_rsp_i.b_valid || axil_rsp_i.r_valid))
    else begin
      $error("Ready or valid high in the first cycle after reset");
      fail_count++;
    end

  rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_i.ar_valid && axil_rsp_i.ar_ready && idle |->
      ##1 !axil_rsp_i.r_valid ##1 !axil_rsp_i.r_valid ##1 !axil_rsp_i.r_valid
      ##1 axil_rsp_i.r_valid)
    else begin
      $error("Read response not exactly 4 cycles after the AR handshake");
      fail_count++;
    end

  wr_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_req_i.aw_valid && axil_rsp_i.aw_ready && idle |->
      ##1 !axil_rsp_i.b_valid ##1 !axil_rsp_i.b_valid ##1 !axil_rsp_i.b_valid
      ##1 axil_rsp_i.b_valid)
    else begin
      $error("Write response not exactly 4 cycles after the AW/W handshake");
      fail_count++;
    end

  // Every stage holds an item and the head cannot leave
  full_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && dec_valid_i && rsp_valid_i && rsp_stuck |->
      !axil_rsp_i.ar_ready && !axil_rsp_i.aw_ready && !axil_rsp_i.w_ready)
    else begin
      $error("Request accepted while the pipeline was full");
      fail_count++;
    end

  ipi_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle |-> ipi_i == msip_shadow_q)
    else begin
      $error("ipi does not follow the last written msip bit");
      fail_count++;
    end

endmodule

bind soc_sim_top soc_sim_assertions u_assertions (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .axil_req_i  ( axil_req_i  ),
  .axil_rsp_i  ( axil_rsp_o  ),
  .req_valid_i ( req_valid   ),
  .dec_valid_i ( dec_valid   ),
  .rsp_valid_i ( rsp_valid   ),
  .ipi_i       ( ipi_o       )
);

`default_nettype wire

// ==== logic/soc_sim_top.sv ====
// Top level of the simulation subsystem, chains request, decode, target and response stages
`default_nettype none

module soc_sim_top import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      rtc_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output logic      timer_irq_o,
  output logic      ipi_o
);

  logic                 req_valid;
  logic                 req_ready;
  bus_req_t             req;
  logic                 dec_valid;
  logic                 dec_ready;
  dec_req_t             dec;
  logic                 rsp_valid;
  logic                 rsp_ready;
  bus_rsp_t             rsp;
  logic                 awready;
  logic                 wready;
  logic                 arready;
  logic                 bvalid;
  logic [1:0]           bresp;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic [1:0]           rresp;

  axil_req_stage i_req_stage (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .axil_req_i  ( axil_req_i ),
    .awready_o   ( awready    ),
    .wready_o    ( wready     ),
    .arready_o   ( arready    ),
    .req_valid_o ( req_valid  ),
    .req_o       ( req        ),
    .req_ready_i ( req_ready  )
  );

  addr_decode_stage i_decode_stage (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .req_valid_i ( req_valid ),
    .req_i       ( req       ),
    .req_ready_o ( req_ready ),
    .dec_valid_o ( dec_valid ),
    .dec_o       ( dec       ),
    .dec_ready_i ( dec_ready )
  );

  target_stage i_target_stage (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .dec_valid_i ( dec_valid   ),
    .dec_i       ( dec         ),
    .dec_ready_o ( dec_ready   ),
    .rsp_valid_o ( rsp_valid   ),
    .rsp_o       ( rsp         ),
    .rsp_ready_i ( rsp_ready   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  axil_rsp_stage i_rsp_stage (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .rsp_valid_i ( rsp_valid          ),
    .rsp_i       ( rsp                ),
    .rsp_ready_o ( rsp_ready          ),
    .bvalid_o    ( bvalid             ),
    .bresp_o     ( bresp              ),
    .bready_i    ( axil_req_i.b_ready ),
    .rvalid_o    ( rvalid             ),
    .rdata_o     ( rdata              ),
    .rresp_o     ( rresp              ),
    .rready_i    ( axil_req_i.r_ready )
  );

  assign axil_rsp_o = '{
    aw_ready: awready,
    w_ready:  wready,
    b_valid:  bvalid,
    b_resp:   bresp,
    ar_ready: arready,
    r_valid:  rvalid,
    r_data:   rdata,
    r_resp:   rresp
  };

endmodule

`default_nettype wire

// ==== logic/axil_rsp_stage.sv ====
// Response stage, holds one response on the B or R channel until the master takes it
`default_nettype none

module axil_rsp_stage import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rsp_valid_i,
  input  bus_rsp_t             rsp_i,
  output logic                 rsp_ready_o,
  output logic                 bvalid_o,
  output logic [1:0]           bresp_o,
  input  logic                 bready_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic [1:0]           rresp_o,
  input  logic                 rready_i
);

  logic     valid_q;
  bus_rsp_t rsp_q;
  logic     leave;

  // Steered by the write flag
  assign bvalid_o = valid_q && rsp_q.write;
  assign rvalid_o = valid_q && !rsp_q.write;
  assign bresp_o  = rsp_q.resp;
  assign rresp_o  = rsp_q.resp;
  assign rdata_o  = rsp_q.rdata;

  assign leave       = (bvalid_o && bready_i) || (rvalid_o && rready_i);
  assign rsp_ready_o = !valid_q || leave;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (rsp_ready_o) begin
      valid_q <= rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i && rsp_ready_o) begin
      rsp_q <= rsp_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/target_stage.sv ====
// Target stage, performs the access on ROM, SRAM, CLINT or error region and forms the response
`default_nettype none

module target_stage import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     dec_valid_i,
  input  dec_req_t dec_i,
  output logic     dec_ready_o,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o,
  input  logic     rsp_ready_i,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic [DataWidth-1:0]     sram_mem [SramWords];
  logic                     valid_q;
  bus_rsp_t                 rsp_q;
  bus_rsp_t                 rsp_d;
  logic                     enter;
  logic [SramIdxWidth-1:0]  sram_idx;
  logic [RomIdxWidth-1:0]   rom_idx;
  logic [AddrWidth-1:0]     clint_addr;
  logic [DataWidth-1:0]     clint_rdata;
  logic                     clint_sel;

  assign dec_ready_o = !valid_q || rsp_ready_i;
  assign enter       = dec_valid_i && dec_ready_o;

  assign sram_idx   = dec_i.req.addr[SramIdxWidth+ByteOffset-1:ByteOffset];
  assign rom_idx    = dec_i.req.addr[RomIdxWidth+ByteOffset-1:ByteOffset];
  assign clint_addr = dec_i.req.addr - ClintBase;
  assign clint_sel  = (dec_i.tgt == TgtClint);

  clint_regs i_clint_regs (
    .clk_i       ( clk_i                               ),
    .rst_ni      ( rst_ni                              ),
    .rtc_i       ( rtc_i                               ),
    .wr_en_i     ( enter && clint_sel && dec_i.req.write ),
    .rd_en_i     ( enter && clint_sel && !dec_i.req.write ),
    .offset_i    ( clint_addr[ClintOffWidth-1:0]       ),
    .wdata_i     ( dec_i.req.wdata                     ),
    .strb_i      ( dec_i.req.strb                      ),
    .rdata_o     ( clint_rdata                         ),
    .timer_irq_o ( timer_irq_o                         ),
    .ipi_o       ( ipi_o                               )
  );

  // ----------------------------------------------------------------------
  // Response forming
  // ----------------------------------------------------------------------
  always_comb begin
    rsp_d.write = dec_i.req.write;
    rsp_d.rdata = '0;
    rsp_d.resp  = RespOkay;
    unique case (dec_i.tgt)
      TgtRom: begin
        if (dec_i.req.write) rsp_d.resp = RespSlvErr;
        else rsp_d.rdata = RomContent[rom_idx];
      end
      TgtSram: begin
        if (!dec_i.req.write) rsp_d.rdata = sram_mem[sram_idx];
      end
      TgtClint: rsp_d.rdata = clint_rdata;
      TgtGpio:  rsp_d.resp  = RespSlvErr;
      default:  rsp_d.resp  = RespDecErr;
    endcase
  end

  // SRAM write lands as the item enters
  always_ff @(posedge clk_i) begin
    if (enter && dec_i.req.write && dec_i.tgt == TgtSram) begin
      sram_mem[sram_idx] <= apply_strb(sram_mem[sram_idx], dec_i.req.wdata, dec_i.req.strb);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (dec_ready_o) begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enter) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== logic/clint_regs.sv ====
// CLINT registers, machine timer on the rtc input, timer compare and software interrupt
`default_nettype none

module clint_regs import soc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rtc_i,
  input  logic                     wr_en_i,
  input  logic                     rd_en_i,
  input  logic [ClintOffWidth-1:0] offset_i,
  input  logic [DataWidth-1:0]     wdata_i,
  input  logic [StrbWidth-1:0]     strb_i,
  output logic [DataWidth-1:0]     rdata_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o
);

  logic [2:0]               rtc_sync_q;
  logic                     rtc_tick;
  logic [DataWidth-1:0]     mtime_q;
  logic [DataWidth-1:0]     mtimecmp_q;
  logic                     msip_q;
  logic [ClintOffWidth-1:0] word_off;

  // Two flops for the async rtc, the third finds the rising edge
  assign rtc_tick = rtc_sync_q[1] && !rtc_sync_q[2];

  // Registers are word aligned
  assign word_off = {offset_i[ClintOffWidth-1:ByteOffset], ByteOffset'(0)};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      if (wr_en_i && word_off == MtimeOffset) begin
        mtime_q <= apply_strb(mtime_q, wdata_i, strb_i);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en_i && word_off == MtimecmpOffset) begin
        mtimecmp_q <= apply_strb(mtimecmp_q, wdata_i, strb_i);
      end
      if (wr_en_i && word_off == MsipOffset && strb_i[0]) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_en_i) begin
      unique case (word_off)
        MsipOffset:     rdata_o = {{(DataWidth-1){1'b0}}, msip_q};
        MtimecmpOffset: rdata_o = mtimecmp_q;
        MtimeOffset:    rdata_o = mtime_q;
        default:        rdata_o = '0;
      endcase
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// ==== logic/addr_decode_stage.sv ====
// Decode stage, tags each request with the target region from the fixed address map
`default_nettype none

module addr_decode_stage import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     req_ready_o,
  output logic     dec_valid_o,
  output dec_req_t dec_o,
  input  logic     dec_ready_i
);

  logic     valid_q;
  dec_req_t dec_q;
  target_e  tgt;

  function automatic logic in_region(
    input logic [AddrWidth-1:0] addr,
    input logic [AddrWidth-1:0] base,
    input logic [AddrWidth-1:0] len
  );
    return (addr >= base) && ((addr - base) < len);
  endfunction

  always_comb begin
    if (in_region(req_i.addr, RomBase, RomLength)) tgt = TgtRom;
    else if (in_region(req_i.addr, SramBase, SramLength)) tgt = TgtSram;
    else if (in_region(req_i.addr, ClintBase, ClintLength)) tgt = TgtClint;
    else if (in_region(req_i.addr, GpioBase, GpioLength)) tgt = TgtGpio;
    else tgt = TgtNone;
  end

  assign req_ready_o = !valid_q || dec_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      dec_q.req <= req_i;
      dec_q.tgt <= tgt;
    end
  end

  assign dec_valid_o = valid_q;
  assign dec_o       = dec_q;

endmodule

`default_nettype wire

// ==== logic/axil_req_stage.sv ====
// Request stage, takes AXI4-Lite reads and joint AW+W writes into one request stream
`default_nettype none

module axil_req_stage import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axil_req_t axil_req_i,
  output logic      awready_o,
  output logic      wready_o,
  output logic      arready_o,
  output logic      req_valid_o,
  output bus_req_t  req_o,
  input  logic      req_ready_i
);

  logic     valid_q;
  logic     last_wr_q;
  bus_req_t req_q;
  bus_req_t req_d;
  logic     slot_free;
  logic     wr_pend;
  logic     rd_pend;
  logic     grant_wr;
  logic     grant_rd;

  assign slot_free = !valid_q || req_ready_i;
  assign wr_pend   = axil_req_i.aw_valid && axil_req_i.w_valid;
  assign rd_pend   = axil_req_i.ar_valid;

  // Round robin, on a tie the side that lost last time goes first
  assign grant_wr = slot_free && wr_pend && (!rd_pend || !last_wr_q);
  assign grant_rd = slot_free && rd_pend && (!wr_pend || last_wr_q);

  assign awready_o = grant_wr;
  assign wready_o  = grant_wr;
  assign arready_o = grant_rd;

  always_comb begin
    if (grant_wr) begin
      req_d.write = 1'b1;
      req_d.addr  = axil_req_i.aw_addr;
      req_d.wdata = axil_req_i.w_data;
      req_d.strb  = axil_req_i.w_strb;
    end else begin
      req_d.write = 1'b0;
      req_d.addr  = axil_req_i.ar_addr;
      req_d.wdata = '0;
      req_d.strb  = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      last_wr_q <= 1'b0;
    end else begin
      if (grant_wr || grant_rd) begin
        valid_q   <= 1'b1;
        last_wr_q <= grant_wr;
      end else if (req_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_wr || grant_rd) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = valid_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

// ==== logic/soc_pkg.sv ====
// Shared sizes, address map, boot ROM image and bus structs, imported by every stage
`default_nettype none

package soc_pkg;

  // ----------------------------------------------------------------------
  // Widths and sizes
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 64;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned ByteOffset    = $clog2(StrbWidth);
  localparam int unsigned SramWords     = 256;
  localparam int unsigned SramIdxWidth  = $clog2(SramWords);
  localparam int unsigned RomWords      = 16;
  localparam int unsigned RomIdxWidth   = $clog2(RomWords);
  localparam int unsigned ClintOffWidth = 16;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_0080;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] GpioBase    = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength  = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] SramBase    = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] SramLength  = AddrWidth'(SramWords * StrbWidth);

  // CLINT register offsets
  localparam logic [ClintOffWidth-1:0] MsipOffset     = 16'h0000;
  localparam logic [ClintOffWidth-1:0] MtimecmpOffset = 16'h4000;
  localparam logic [ClintOffWidth-1:0] MtimeOffset    = 16'hBFF8;

  // Boot image, jumps to the start of SRAM
  localparam logic [DataWidth-1:0] RomContent [RomWords] = '{
    64'h0000_0297_0202_8293, 64'h3002_9073_0000_0513,
    64'h0000_0593_8000_02b7, 64'h0002_8067_0000_0013,
    64'h1050_0073_ffdf_f06f, 64'h0000_0000_0000_0013,
    64'hdead_beef_0000_0001, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5555_aaaa_5555_aaaa,
    64'h0f0f_0f0f_f0f0_f0f0, 64'h8000_0000_0200_0000,
    64'h0000_0000_0001_0000, 64'h1111_2222_3333_4444,
    64'hc0de_cafe_f00d_0042, 64'h0000_0000_0000_0000
  };

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;
  localparam logic [1:0] RespDecErr = 2'b11;

  typedef enum logic [2:0] {
    TgtRom,
    TgtSram,
    TgtClint,
    TgtGpio,
    TgtNone
  } target_e;

  // ----------------------------------------------------------------------
  // Bus structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    logic [1:0]           b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    logic [1:0]           r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } bus_req_t;

  typedef struct packed {
    bus_req_t req;
    target_e  tgt;
  } dec_req_t;

  typedef struct packed {
    logic                 write;
    logic [DataWidth-1:0] rdata;
    logic [1:0]           resp;
  } bus_rsp_t;

  // Byte lane merge for strobed writes
  function automatic logic [DataWidth-1:0] apply_strb(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] new_data,
    input logic [StrbWidth-1:0] strb
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
